// File: design/sorter_cfg_pkg.sv
// Geometry of the transaction sorter ring
// SLOTS must be a power of two so that the ring pointers wrap on their own

package sorter_cfg_pkg;

    // Ring depth, which is also the limit on transactions in flight
    localparam int SLOTS = 8;

    // Number of confirmation lanes checked every cycle
    localparam int CONF_LANES = 2;

    // Width of a slot index
    localparam int PTR_WIDTH = $clog2(SLOTS);

    typedef logic [PTR_WIDTH-1:0] ptr_t;

endpackage

// File: design/trans_admit.sv
// Admission side of the sorter ring
// Input stalls while the ring is full or while rx_id matches an in-flight ID,
// so rx_dst_rdy depends combinationally on rx_id

`timescale 1ns/1ps

module trans_admit (
    input  logic                                clk,
    input  logic                                rst,
    input  trans_pkg::id_t                      rx_id,
    input  trans_pkg::meta_t                    rx_meta,
    input  logic                                rx_src_rdy,
    output logic                                rx_dst_rdy,
    input  logic [sorter_cfg_pkg::SLOTS-1:0]    id_hit,
    input  logic                                pop,
    output logic [sorter_cfg_pkg::SLOTS-1:0]    wr_en,
    output trans_pkg::id_t                      wr_id,
    output trans_pkg::meta_t                    wr_meta
);
    import sorter_cfg_pkg::*;

    ptr_t               tail;
    logic [PTR_WIDTH:0] count;
    logic               ring_full;
    logic               accept;

    assign ring_full  = (count == (PTR_WIDTH + 1)'(SLOTS));

    // A duplicate ID anywhere in the ring holds the input off
    assign rx_dst_rdy = !ring_full && !(|id_hit);
    assign accept     = rx_src_rdy && rx_dst_rdy;

    // The tail slot takes the incoming transaction at the end of the cycle
    always_comb begin
        wr_en = '0;
        if (accept) begin
            wr_en[tail] = 1'b1;
        end
    end

    assign wr_id   = rx_id;
    assign wr_meta = rx_meta;

    always_ff @(posedge clk) begin
        if (rst) begin
            tail  <= '0;
            count <= '0;
        end else begin
            if (accept) begin
                tail <= tail + 1'b1;
            end
            // Accept and pop in the same cycle leave the count unchanged
            case ({accept, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: design/trans_pkg.sv
// Transaction format shared by the sorter and its testbench
// IDs and metadata are plain unsigned fields with no internal structure

package trans_pkg;

    // Width of a transaction ID
    localparam int ID_WIDTH = 8;

    // Width of the metadata that travels with each ID
    localparam int META_WIDTH = 16;

    typedef logic [ID_WIDTH-1:0] id_t;
    typedef logic [META_WIDTH-1:0] meta_t;

endpackage

// File: design/trans_release.sv
// Release side of the sorter ring
// Only the head slot is ever offered, so a confirmed entry behind an
// unconfirmed head waits. Output fields come straight from the slot registers
// and hold still under back-pressure

`timescale 1ns/1ps

module trans_release (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [sorter_cfg_pkg::SLOTS-1:0]    slot_rdy,
    input  trans_pkg::id_t                      slot_id [sorter_cfg_pkg::SLOTS],
    input  trans_pkg::meta_t                    slot_meta [sorter_cfg_pkg::SLOTS],
    output trans_pkg::id_t                      tx_id,
    output trans_pkg::meta_t                    tx_meta,
    output logic                                tx_src_rdy,
    input  logic                                tx_dst_rdy,
    output logic [sorter_cfg_pkg::SLOTS-1:0]    clr,
    output logic                                pop
);
    import sorter_cfg_pkg::*;

    ptr_t head;

    // Head slot drives the transmit side
    assign tx_src_rdy = slot_rdy[head];
    assign tx_id      = slot_id[head];
    assign tx_meta    = slot_meta[head];

    assign pop = tx_src_rdy && tx_dst_rdy;

    // The popped slot empties at the edge that ends the transfer cycle
    always_comb begin
        clr = '0;
        if (pop) begin
            clr[head] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
        end else if (pop) begin
            head <= head + 1'b1;
        end
    end

endmodule

// File: design/trans_slot.sv
// One entry of the sorter ring
// A slot only takes confirmations once it is occupied, so a confirmation
// in the same cycle as the write is not seen

`timescale 1ns/1ps

module trans_slot (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    wr_en,
    input  trans_pkg::id_t                          wr_id,
    input  trans_pkg::meta_t                        wr_meta,
    input  trans_pkg::id_t                          rx_id,
    input  trans_pkg::id_t                          conf_id [sorter_cfg_pkg::CONF_LANES],
    input  logic [sorter_cfg_pkg::CONF_LANES-1:0]   conf_vld,
    input  logic                                    clr,
    output logic                                    id_hit,
    output logic                                    slot_rdy,
    output trans_pkg::id_t                          slot_id,
    output trans_pkg::meta_t                        slot_meta
);
    import sorter_cfg_pkg::*;

    logic occupied;
    logic confirmed;
    logic conf_match;

    // Any valid lane carrying the stored ID counts as a confirmation
    always_comb begin
        conf_match = 1'b0;
        for (int i = 0; i < CONF_LANES; i++) begin
            if (conf_vld[i] && (conf_id[i] == slot_id)) begin
                conf_match = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied  <= 1'b0;
            confirmed <= 1'b0;
        end else if (clr) begin
            occupied  <= 1'b0;
            confirmed <= 1'b0;
        end else if (wr_en) begin
            occupied  <= 1'b1;
            confirmed <= 1'b0;
        end else if (occupied && conf_match) begin
            confirmed <= 1'b1;
        end
    end

    // Payload is only meaningful while occupied is set
    always_ff @(posedge clk) begin
        if (wr_en) begin
            slot_id   <= wr_id;
            slot_meta <= wr_meta;
        end
    end

    assign id_hit   = occupied && (slot_id == rx_id);
    assign slot_rdy = occupied && confirmed;

endmodule

// File: design/trans_sorter.sv
// Transaction sorter top level
// Transactions leave in arrival order once their ID is confirmed.
// In-flight IDs are unique since a duplicate stalls the input.
// Confirmations for IDs not in flight are dropped

`timescale 1ns/1ps

module trans_sorter (
    input  logic                                    clk,
    input  logic                                    rst,
    input  trans_pkg::id_t                          rx_id,
    input  trans_pkg::meta_t                        rx_meta,
    input  logic                                    rx_src_rdy,
    output logic                                    rx_dst_rdy,
    input  trans_pkg::id_t                          conf_id [sorter_cfg_pkg::CONF_LANES],
    input  logic [sorter_cfg_pkg::CONF_LANES-1:0]   conf_vld,
    output trans_pkg::id_t                          tx_id,
    output trans_pkg::meta_t                        tx_meta,
    output logic                                    tx_src_rdy,
    input  logic                                    tx_dst_rdy
);
    import trans_pkg::*;
    import sorter_cfg_pkg::*;

    // Admit block to slots
    logic [SLOTS-1:0] wr_en;
    id_t              wr_id;
    meta_t            wr_meta;

    // Slots to admit and release blocks
    logic [SLOTS-1:0] id_hit;
    logic [SLOTS-1:0] slot_rdy;
    id_t              slot_id [SLOTS];
    meta_t            slot_meta [SLOTS];

    // Release block to slots and admit block
    logic [SLOTS-1:0] clr;
    logic             pop;

    trans_admit u_trans_admit (
        .clk        (clk),
        .rst        (rst),
        .rx_id      (rx_id),
        .rx_meta    (rx_meta),
        .rx_src_rdy (rx_src_rdy),
        .rx_dst_rdy (rx_dst_rdy),
        .id_hit     (id_hit),
        .pop        (pop),
        .wr_en      (wr_en),
        .wr_id      (wr_id),
        .wr_meta    (wr_meta)
    );

    // Every slot sees the same write data, rx_id and confirmation lanes
    for (genvar i = 0; i < SLOTS; i++) begin : g_slot
        trans_slot u_trans_slot (
            .clk       (clk),
            .rst       (rst),
            .wr_en     (wr_en[i]),
            .wr_id     (wr_id),
            .wr_meta   (wr_meta),
            .rx_id     (rx_id),
            .conf_id   (conf_id),
            .conf_vld  (conf_vld),
            .clr       (clr[i]),
            .id_hit    (id_hit[i]),
            .slot_rdy  (slot_rdy[i]),
            .slot_id   (slot_id[i]),
            .slot_meta (slot_meta[i])
        );
    end

    trans_release u_trans_release (
        .clk        (clk),
        .rst        (rst),
        .slot_rdy   (slot_rdy),
        .slot_id    (slot_id),
        .slot_meta  (slot_meta),
        .tx_id      (tx_id),
        .tx_meta    (tx_meta),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy),
        .clr        (clr),
        .pop        (pop)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the sorter testbench with Verilator, runs it and looks for the pass line

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator is not installed or not on PATH"
    exit 1
fi

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
    --top-module trans_sorter_tb -Mdir obj_dir -o trans_sorter_tb
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/trans_sorter_tb)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TB PASSED" <<< "$sim_output"; then
    exit 0
fi
exit 1

// File: sim/trans_sorter_tb.sv
// Random and directed testbench for the transaction sorter
// Inputs change on the falling edge, outputs are sampled a quarter period later
// The reference model is a queue of in-flight entries in arrival order

`timescale 1ns/1ps

module trans_sorter_tb;
    import trans_pkg::*;
    import sorter_cfg_pkg::*;

    localparam int CLK_PERIOD = 40;

    logic                  clk;
    logic                  rst;
    id_t                   rx_id;
    meta_t                 rx_meta;
    logic                  rx_src_rdy;
    logic                  rx_dst_rdy;
    id_t                   conf_id [CONF_LANES];
    logic [CONF_LANES-1:0] conf_vld;
    id_t                   tx_id;
    meta_t                 tx_meta;
    logic                  tx_src_rdy;
    logic                  tx_dst_rdy;

    // Values applied at the next falling edge
    id_t                   next_rx_id;
    meta_t                 next_rx_meta;
    logic                  next_rx_src_rdy;
    id_t                   next_conf_id [CONF_LANES];
    logic [CONF_LANES-1:0] next_conf_vld;
    logic                  next_tx_dst_rdy;

    // Reference model, oldest entry first
    id_t   q_id [$];
    meta_t q_meta [$];
    logic  q_conf [$];

    // IDs the DUT actually sent on tx, in order
    id_t   popped [$];

    logic last_accept;
    logic last_pop;
    logic seen_rx_rdy;
    logic seen_tx_rdy;
    int   errors;
    int   checks;
    int   tests_run;

    trans_sorter u_trans_sorter (
        .clk        (clk),
        .rst        (rst),
        .rx_id      (rx_id),
        .rx_meta    (rx_meta),
        .rx_src_rdy (rx_src_rdy),
        .rx_dst_rdy (rx_dst_rdy),
        .conf_id    (conf_id),
        .conf_vld   (conf_vld),
        .tx_id      (tx_id),
        .tx_meta    (tx_meta),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Input is free when the ring has room and rx_id is not in flight
    function automatic logic model_rx_ready(input id_t id);
        if (q_id.size() >= SLOTS) begin
            return 1'b0;
        end
        foreach (q_id[i]) begin
            if (q_id[i] == id) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic run_cycle();
        logic exp_rx_rdy;
        logic exp_tx_rdy;
        @(negedge clk);
        rx_id      = next_rx_id;
        rx_meta    = next_rx_meta;
        rx_src_rdy = next_rx_src_rdy;
        conf_id    = next_conf_id;
        conf_vld   = next_conf_vld;
        tx_dst_rdy = next_tx_dst_rdy;
        #(CLK_PERIOD / 4);
        exp_rx_rdy  = model_rx_ready(rx_id);
        exp_tx_rdy  = (q_id.size() > 0) && q_conf[0];
        seen_rx_rdy = rx_dst_rdy;
        seen_tx_rdy = tx_src_rdy;
        check_value("rx_dst_rdy", 32'(rx_dst_rdy), 32'(exp_rx_rdy));
        check_value("tx_src_rdy", 32'(tx_src_rdy), 32'(exp_tx_rdy));
        if (exp_tx_rdy) begin
            check_value("tx_id", 32'(tx_id), 32'(q_id[0]));
            check_value("tx_meta", 32'(tx_meta), 32'(q_meta[0]));
        end
        if (tx_src_rdy && tx_dst_rdy) begin
            popped.push_back(tx_id);
        end
        last_accept = rx_src_rdy && exp_rx_rdy;
        last_pop    = exp_tx_rdy && tx_dst_rdy;
        // Confirmations reach only entries that were accepted before this cycle
        for (int i = 0; i < q_id.size(); i++) begin
            for (int l = 0; l < CONF_LANES; l++) begin
                if (conf_vld[l] && (conf_id[l] == q_id[i])) begin
                    q_conf[i] = 1'b1;
                end
            end
        end
        if (last_pop) begin
            q_id.delete(0);
            q_meta.delete(0);
            q_conf.delete(0);
        end
        if (last_accept) begin
            q_id.push_back(rx_id);
            q_meta.push_back(rx_meta);
            q_conf.push_back(1'b0);
        end
    endtask

    task automatic wait_accept(input int limit);
        int waited;
        waited = 0;
        run_cycle();
        while (!last_accept && waited < limit) begin
            run_cycle();
            waited++;
        end
        if (!last_accept) begin
            $display("timeout: no transaction was accepted on rx within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic send(input id_t id, input meta_t meta);
        next_rx_id      = id;
        next_rx_meta    = meta;
        next_rx_src_rdy = 1'b1;
        wait_accept(20);
        next_rx_src_rdy = 1'b0;
    endtask

    task automatic confirm(input id_t id, input int lane);
        next_conf_id[lane]  = id;
        next_conf_vld[lane] = 1'b1;
        run_cycle();
        next_conf_vld[lane] = 1'b0;
    endtask

    task automatic drain_all(input int limit);
        int waited;
        waited          = 0;
        next_tx_dst_rdy = 1'b1;
        while (q_id.size() > 0 && waited < limit) begin
            run_cycle();
            waited++;
        end
        if (q_id.size() > 0) begin
            $display("timeout: %0d transactions did not leave within %0d cycles",
                     q_id.size(), limit);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests_run++;
        $display("test %-8s %s, %0d errors", name,
                 (errors == errs_at_start) ? "ok" : "failed", errors - errs_at_start);
    endtask

    task automatic after_reset();
        int errs_at_start;
        errs_at_start = errors;
        run_cycle();
        check_value("tx_src_rdy", 32'(seen_tx_rdy), 32'(0));
        check_value("rx_dst_rdy", 32'(seen_rx_rdy), 32'(1));
        finish_test("reset", errs_at_start);
    endtask

    task automatic reverse_order();
        int errs_at_start;
        errs_at_start = errors;
        popped.delete();
        next_tx_dst_rdy = 1'b1;
        for (int i = 0; i < 4; i++) begin
            send(id_t'(8'h10 + i), meta_t'($urandom));
        end
        // Reverse order, so every entry waits on the one ahead of it
        for (int i = 3; i >= 0; i--) begin
            confirm(id_t'(8'h10 + i), i % 2);
        end
        drain_all(20);
        check_value("tx count", 32'(popped.size()), 32'(4));
        foreach (popped[k]) begin
            check_value("tx_id order", 32'(popped[k]), 32'(8'h10 + k));
        end
        finish_test("ordering", errs_at_start);
    endtask

    task automatic dup_stall();
        int errs_at_start;
        errs_at_start   = errors;
        next_tx_dst_rdy = 1'b1;
        send(8'h20, meta_t'($urandom));
        next_rx_id      = 8'h20;
        next_rx_meta    = meta_t'($urandom);
        next_rx_src_rdy = 1'b1;
        repeat (3) begin
            run_cycle();
            check_value("rx_dst_rdy", 32'(seen_rx_rdy), 32'(0));
        end
        // Once the first 0x20 leaves, the second one gets in
        confirm(8'h20, 1);
        wait_accept(10);
        next_rx_src_rdy = 1'b0;
        confirm(8'h20, 0);
        drain_all(10);
        finish_test("dup", errs_at_start);
    endtask

    task automatic full_ring();
        int errs_at_start;
        errs_at_start   = errors;
        next_tx_dst_rdy = 1'b1;
        for (int i = 0; i < SLOTS; i++) begin
            send(id_t'(8'h30 + i), meta_t'($urandom));
        end
        next_rx_id      = 8'h40;
        next_rx_meta    = meta_t'($urandom);
        next_rx_src_rdy = 1'b1;
        run_cycle();
        check_value("rx_dst_rdy", 32'(seen_rx_rdy), 32'(0));
        confirm(8'h30, 0);
        wait_accept(10);
        next_rx_src_rdy = 1'b0;
        // Hold tx off so the confirmed entries pile up behind the head
        next_tx_dst_rdy = 1'b0;
        for (int i = 1; i < SLOTS; i++) begin
            confirm(id_t'(8'h30 + i), i % 2);
        end
        confirm(8'h40, 0);
        drain_all(40);
        finish_test("full", errs_at_start);
    endtask

    task automatic stray_confirms();
        int errs_at_start;
        errs_at_start   = errors;
        popped.delete();
        next_tx_dst_rdy = 1'b1;
        send(8'h50, meta_t'($urandom));
        for (int k = 0; k < 4; k++) begin
            next_conf_id[0] = id_t'(8'h60 + k);
            next_conf_id[1] = id_t'(8'h70 + k);
            next_conf_vld   = '1;
            run_cycle();
            check_value("tx_src_rdy", 32'(seen_tx_rdy), 32'(0));
        end
        // A confirmation in the accepting cycle itself does not count
        next_conf_id[0] = 8'h51;
        next_conf_vld   = 2'b01;
        send(8'h51, meta_t'($urandom));
        next_conf_vld = '0;
        confirm(8'h50, 1);
        run_cycle();
        repeat (3) begin
            run_cycle();
            check_value("tx_src_rdy", 32'(seen_tx_rdy), 32'(0));
        end
        confirm(8'h51, 0);
        drain_all(10);
        check_value("tx count", 32'(popped.size()), 32'(2));
        finish_test("stray", errs_at_start);
    endtask

    task automatic random_traffic();
        int errs_at_start;
        int accepts;
        int transfers;
        errs_at_start = errors;
        accepts       = 0;
        transfers     = 0;
        for (int cyc = 0; cyc < 2000; cyc++) begin
            // A small ID pool keeps duplicate stalls frequent
            next_rx_src_rdy = 1'($urandom_range(0, 1));
            next_rx_id      = id_t'($urandom_range(0, 15));
            next_rx_meta    = meta_t'($urandom);
            for (int l = 0; l < CONF_LANES; l++) begin
                next_conf_vld[l] = 1'b0;
                if (q_id.size() > 0 && $urandom_range(0, 3) == 0) begin
                    next_conf_id[l]  = q_id[$urandom_range(0, q_id.size() - 1)];
                    next_conf_vld[l] = 1'b1;
                end else if ($urandom_range(0, 7) == 0) begin
                    next_conf_id[l]  = id_t'($urandom);
                    next_conf_vld[l] = 1'b1;
                end
            end
            next_tx_dst_rdy = ($urandom_range(0, 3) != 0);
            run_cycle();
            accepts   += int'(last_accept);
            transfers += int'(last_pop);
        end
        next_rx_src_rdy = 1'b0;
        next_conf_vld   = '0;
        // Hold tx off so the queue stays put while every entry is confirmed
        next_tx_dst_rdy = 1'b0;
        for (int i = 0; i < q_id.size(); i++) begin
            confirm(q_id[i], i % 2);
        end
        drain_all(40);
        if (transfers == 0) begin
            $display("random traffic moved no transaction through the sorter");
            errors++;
        end
        $display("random traffic: %0d accepted, %0d sent during the run", accepts, transfers);
        finish_test("random", errs_at_start);
    endtask

    initial begin
        void'($urandom(48));
        errors          = 0;
        checks          = 0;
        tests_run       = 0;
        rst             = 1'b1;
        rx_id           = '0;
        rx_meta         = '0;
        rx_src_rdy      = 1'b0;
        conf_id         = '{default: '0};
        conf_vld        = '0;
        tx_dst_rdy      = 1'b0;
        next_rx_id      = '0;
        next_rx_meta    = '0;
        next_rx_src_rdy = 1'b0;
        next_conf_id    = '{default: '0};
        next_conf_vld   = '0;
        next_tx_dst_rdy = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        after_reset();
        reverse_order();
        dup_stall();
        full_ring();
        stray_confirms();
        random_traffic();
        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/trans_pkg.sv
design/sorter_cfg_pkg.sv
design/trans_admit.sv
design/trans_slot.sv
design/trans_release.sv
design/trans_sorter.sv
sim/trans_sorter_tb.sv
